// ==== logic/core_pkg.sv ====
`default_nettype none

package core_pkg;

	localparam int WORD_W      = 32;
	localparam int NUM_REGS    = 32;
	// cycles the memory may take to raise or drop its ack
	localparam int BUS_TIMEOUT = 16;
	localparam int BUS_CNT_W   = $clog2(BUS_TIMEOUT + 1);

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [4:0]        reg_idx_t;
	// load-word scale
	typedef logic [1:0]        shamt_t;

	typedef enum logic [2:0] {
		ALUSRC2_RBDATA,
		ALUSRC2_IMM,
		ALUSRC2_LSWI,
		ALUSRC2_LSW,
		ALUSRC2_BENX
	} alu_src2_sel_t;

	typedef enum logic [2:0] {
		IMM_5BIT_ZE,
		IMM_15BIT_SE,
		IMM_15BIT_ZE,
		IMM_20BIT_SE,
		IMM_20BIT_HI
	} imm_sel_t;

	typedef enum logic [1:0] {
		WRREG_ALURESULT,
		WRREG_IMMDATA,
		WRREG_MEM
	} wr_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SEQ
	} alu_op_t;

	typedef struct packed {
		alu_src2_sel_t alu_src2_sel;
		imm_sel_t      imm_sel;
		wr_sel_t       wr_sel;
		alu_op_t       alu_op;
		logic          reg_we;
		logic          mem_rd;
		logic          mem_wr;
	} ctrl_t;

	typedef enum logic [2:0] {
		IDLE,
		EXEC,
		MEM_REQ,
		MEM_REL,
		WB,
		ACK,
		ACK_REL
	} state_t;

endpackage

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

	typedef enum logic [6:0] {
		// reg-reg
		OP_ADD   = 7'h01,
		OP_SUB   = 7'h02,
		OP_AND   = 7'h03,
		OP_OR    = 7'h04,
		OP_XOR   = 7'h05,
		OP_SEQ   = 7'h06,
		// immediate forms
		OP_ADDI  = 7'h10,
		OP_ORI   = 7'h11,
		OP_SLLI  = 7'h12,
		OP_MOVI  = 7'h13,
		OP_SETHI = 7'h14,
		// memory
		OP_LWI   = 7'h20,
		OP_LW    = 7'h21,
		OP_SWI   = 7'h22
	} opcode_t;

	// tail is {rb, sv, ...} for reg-reg, imm5 in [4:0] for SLLI,
	// imm15 for I-type; imm20 is {ra, tail}
	typedef struct packed {
		opcode_t           op;
		core_pkg::reg_idx_t rt;
		core_pkg::reg_idx_t ra;
		logic [14:0]       tail;
	} inst_t;

endpackage

`default_nettype wire

// ==== logic/muxs.sv ====
`timescale 1ns/1ps
`default_nettype none

module muxs
	import core_pkg::*;
(
	input  shamt_t        sub_op_sv,
	input  word_t         reg_rb_data,
	input  word_t         reg_rt_data,
	input  word_t         alu_result,
	input  word_t         xreg3_imm_extend,
	input  word_t         mem_read_data,
	input  logic [4:0]    imm_5bit,
	input  logic [14:0]   imm_15bit,
	input  logic [19:0]   imm_20bit,
	input  alu_src2_sel_t select_alu_src2,
	input  imm_sel_t      select_imm_extend,
	input  wr_sel_t       select_write_reg,
	output word_t         imm_extend,
	output word_t         alu_src2,
	output word_t         write_reg_data
);

	always_comb begin
		case (select_imm_extend)
			IMM_5BIT_ZE:
				imm_extend = {27'b0, imm_5bit};
			IMM_15BIT_SE:
				imm_extend = {{17{imm_15bit[14]}}, imm_15bit};
			IMM_15BIT_ZE:
				imm_extend = {17'b0, imm_15bit};
			IMM_20BIT_SE:
				imm_extend = {{12{imm_20bit[19]}}, imm_20bit};
			IMM_20BIT_HI:
				imm_extend = {imm_20bit, 12'b0};
			default:
				imm_extend = '0;
		endcase
	end

	always_comb begin
		case (select_alu_src2)
			ALUSRC2_RBDATA:
				alu_src2 = reg_rb_data;
			ALUSRC2_IMM:
				alu_src2 = imm_extend;
			// word offset, scaled by 4
			ALUSRC2_LSWI:
				alu_src2 = {{15{imm_15bit[14]}}, imm_15bit, 2'b00};
			ALUSRC2_LSW:
				alu_src2 = reg_rb_data << sub_op_sv;
			ALUSRC2_BENX:
				alu_src2 = reg_rt_data;
			default:
				alu_src2 = '0;
		endcase
	end

	// immediate comes from the registered copy, not the live one
	always_comb begin
		case (select_write_reg)
			WRREG_ALURESULT:
				write_reg_data = alu_result;
			WRREG_IMMDATA:
				write_reg_data = xreg3_imm_extend;
			WRREG_MEM:
				write_reg_data = mem_read_data;
			default:
				write_reg_data = '0;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
	import core_pkg::*;
(
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   y
);

	logic [4:0] shamt;
	logic       equal;

	assign shamt = b[4:0];
	assign equal = (a == b);

	always_comb begin
		case (op)
			ALU_ADD: begin
				y = a + b;
			end
			ALU_SUB: begin
				y = a - b;
			end
			ALU_AND: begin
				y = a & b;
			end
			ALU_OR: begin
				y = a | b;
			end
			ALU_XOR: begin
				y = a ^ b;
			end
			ALU_SLL: begin
				y = a << shamt;
			end
			// 1 on match, else 0
			ALU_SEQ: begin
				y = {31'b0, equal};
			end
			default: begin
				y = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file
	import core_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t ra_idx,
	input  reg_idx_t rb_idx,
	input  reg_idx_t rt_idx,
	input  reg_idx_t dbg_idx,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	output word_t    ra_data,
	output word_t    rb_data,
	output word_t    rt_data,
	output word_t    dbg_data
);

	word_t regs [NUM_REGS];

	// r0 is writable like any other
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign ra_data  = regs[ra_idx];
	assign rb_data  = regs[rb_idx];
	assign rt_data  = regs[rt_idx];
	assign dbg_data = regs[dbg_idx];

endmodule

`default_nettype wire

// ==== logic/bus_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_timer
	import core_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic run,
	output logic expired
);

	logic [BUS_CNT_W-1:0] count;

	// holds at the limit until run drops
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (!run) begin
			count <= '0;
		end else if (!expired) begin
			count <= count + 1'b1;
		end
	end

	assign expired = (count == BUS_CNT_W'(BUS_TIMEOUT));

endmodule

`default_nettype wire

// ==== logic/core_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_fsm
	import core_pkg::*;
	import isa_pkg::*;
(
	input  logic  clk,
	input  logic  rst_n,
	input  logic  inst_req,
	input  inst_t inst,
	output logic  inst_ack,
	output logic  mem_req,
	output logic  mem_we,
	input  logic  mem_ack,
	input  logic  expired,
	output logic  timer_run,
	output ctrl_t ctrl,
	output inst_t fields,
	output word_t imm_q,
	input  word_t imm_d,
	output word_t mem_data_q,
	input  word_t mem_rdata,
	output logic  bus_err
);

	state_t state;
	state_t state_nx;
	ctrl_t  dec;
	logic   is_mem;
	logic   timeout;
	logic   abort;

	// decode of the latched opcode
	always_comb begin
		dec = '0;
		dec.alu_src2_sel = ALUSRC2_RBDATA;
		dec.imm_sel = IMM_15BIT_SE;
		dec.wr_sel = WRREG_ALURESULT;
		dec.alu_op = ALU_ADD;
		case (fields.op)
			OP_ADD: begin
				dec.reg_we = 1'b1;
			end
			OP_SUB: begin
				dec.alu_op = ALU_SUB;
				dec.reg_we = 1'b1;
			end
			OP_AND: begin
				dec.alu_op = ALU_AND;
				dec.reg_we = 1'b1;
			end
			OP_OR: begin
				dec.alu_op = ALU_OR;
				dec.reg_we = 1'b1;
			end
			OP_XOR: begin
				dec.alu_op = ALU_XOR;
				dec.reg_we = 1'b1;
			end
			// rt = (ra == rt)
			OP_SEQ: begin
				dec.alu_src2_sel = ALUSRC2_BENX;
				dec.alu_op = ALU_SEQ;
				dec.reg_we = 1'b1;
			end
			OP_ADDI: begin
				dec.alu_src2_sel = ALUSRC2_IMM;
				dec.reg_we = 1'b1;
			end
			OP_ORI: begin
				dec.alu_src2_sel = ALUSRC2_IMM;
				dec.imm_sel = IMM_15BIT_ZE;
				dec.alu_op = ALU_OR;
				dec.reg_we = 1'b1;
			end
			OP_SLLI: begin
				dec.alu_src2_sel = ALUSRC2_IMM;
				dec.imm_sel = IMM_5BIT_ZE;
				dec.alu_op = ALU_SLL;
				dec.reg_we = 1'b1;
			end
			OP_MOVI, OP_SETHI: begin
				dec.imm_sel = (fields.op == OP_MOVI) ? IMM_20BIT_SE : IMM_20BIT_HI;
				dec.wr_sel = WRREG_IMMDATA;
				dec.reg_we = 1'b1;
			end
			OP_LWI, OP_LW: begin
				dec.alu_src2_sel = (fields.op == OP_LWI) ? ALUSRC2_LSWI : ALUSRC2_LSW;
				dec.wr_sel = WRREG_MEM;
				dec.reg_we = 1'b1;
				dec.mem_rd = 1'b1;
			end
			OP_SWI: begin
				dec.alu_src2_sel = ALUSRC2_LSWI;
				dec.mem_wr = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		ctrl = dec;
		ctrl.reg_we = dec.reg_we && (state == WB);
	end

	assign is_mem = dec.mem_rd | dec.mem_wr;
	// timer runs only while waiting on the memory ack edge
	assign timer_run = ((state == MEM_REQ) && !mem_ack) || ((state == MEM_REL) && mem_ack);
	assign timeout = timer_run && expired;

	always_comb begin
		state_nx = state;
		case (state)
			IDLE:    if (inst_req) state_nx = EXEC;
			EXEC:    state_nx = is_mem ? MEM_REQ : WB;
			MEM_REQ: if (mem_ack || timeout) state_nx = MEM_REL;
			MEM_REL: begin
				if (!mem_ack) begin
					state_nx = abort ? ACK : WB;
				end else if (timeout) begin
					state_nx = ACK;
				end
			end
			WB:      state_nx = ACK;
			ACK:     state_nx = ACK_REL;
			ACK_REL: if (!inst_req) state_nx = IDLE;
			default: state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			inst_ack <= 1'b0;
			mem_req <= 1'b0;
			mem_we <= 1'b0;
			bus_err <= 1'b0;
			abort <= 1'b0;
		end else begin
			state <= state_nx;
			if (state == ACK) begin
				inst_ack <= 1'b1;
			end else if ((state == ACK_REL) && !inst_req) begin
				inst_ack <= 1'b0;
			end
			if ((state == EXEC) && is_mem) begin
				mem_req <= 1'b1;
				mem_we <= dec.mem_wr;
			end else if ((state == MEM_REQ) && (mem_ack || timeout)) begin
				mem_req <= 1'b0;
				mem_we <= 1'b0;
			end
			if (timeout) begin
				bus_err <= 1'b1;
				abort <= 1'b1;
			end else if (state == IDLE) begin
				abort <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if ((state == IDLE) && inst_req) begin
			fields <= inst;
		end
		// xREG3 copy of the immediate
		if (state == EXEC) begin
			imm_q <= imm_d;
		end
		if ((state == MEM_REQ) && mem_ack) begin
			mem_data_q <= mem_rdata;
		end
	end

endmodule

`default_nettype wire

// ==== logic/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core
	import core_pkg::*;
	import isa_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     inst_req,
	input  inst_t    inst,
	output logic     inst_ack,
	output logic     mem_req,
	output logic     mem_we,
	output word_t    mem_addr,
	output word_t    mem_wdata,
	input  logic     mem_ack,
	input  word_t    mem_rdata,
	input  reg_idx_t dbg_idx,
	output word_t    dbg_data,
	output logic     bus_err
);

	ctrl_t    ctrl;
	inst_t    fields;
	word_t    imm_q;
	word_t    imm_d;
	word_t    mem_data_q;
	word_t    ra_data;
	word_t    rb_data;
	word_t    rt_data;
	word_t    alu_src2;
	word_t    alu_result;
	word_t    wr_data;
	logic     timer_run;
	logic     expired;
	reg_idx_t rb_idx;
	shamt_t   sv;

	// reg-reg tail is {rb, sv, ...}
	assign rb_idx = fields.tail[14:10];
	assign sv = fields.tail[9:8];

	assign mem_addr = alu_result;
	assign mem_wdata = rt_data;

	core_fsm fsm_i (
		.clk(clk), .rst_n(rst_n),
		.inst_req(inst_req), .inst(inst), .inst_ack(inst_ack),
		.mem_req(mem_req), .mem_we(mem_we), .mem_ack(mem_ack),
		.expired(expired), .timer_run(timer_run),
		.ctrl(ctrl), .fields(fields), .imm_q(imm_q), .imm_d(imm_d),
		.mem_data_q(mem_data_q), .mem_rdata(mem_rdata), .bus_err(bus_err)
	);

	bus_timer timer_i (.clk(clk), .rst_n(rst_n), .run(timer_run), .expired(expired));

	reg_file rf_i (
		.clk(clk), .rst_n(rst_n),
		.ra_idx(fields.ra), .rb_idx(rb_idx), .rt_idx(fields.rt), .dbg_idx(dbg_idx),
		.we(ctrl.reg_we), .wr_idx(fields.rt), .wr_data(wr_data),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data), .dbg_data(dbg_data)
	);

	muxs muxs_i (
		.sub_op_sv(sv), .reg_rb_data(rb_data), .reg_rt_data(rt_data),
		.alu_result(alu_result), .xreg3_imm_extend(imm_q), .mem_read_data(mem_data_q),
		.imm_5bit(fields.tail[4:0]), .imm_15bit(fields.tail),
		.imm_20bit({fields.ra, fields.tail}),
		.select_alu_src2(ctrl.alu_src2_sel), .select_imm_extend(ctrl.imm_sel),
		.select_write_reg(ctrl.wr_sel),
		.imm_extend(imm_d), .alu_src2(alu_src2), .write_reg_data(wr_data)
	);

	alu alu_i (.op(ctrl.alu_op), .a(ra_data), .b(alu_src2), .y(alu_result));

endmodule

`default_nettype wire

// ==== tests/exec_core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core_chk
	import core_pkg::*;
(
	input logic  clk,
	input logic  rst_n,
	input logic  inst_req,
	input logic  inst_ack,
	input logic  mem_req,
	input logic  mem_ack,
	input word_t mem_addr,
	input logic  bus_err
);

	// issue ack only answers a pending request
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(inst_ack) |-> inst_req)
		else $error("inst_ack rose while inst_req was low");

	// a request waits for its ack, unless the bus timer gives up
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_req && !mem_ack) |=> (mem_req || $rose(bus_err)))
		else $error("mem_req dropped before mem_ack without a bus error");

	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req |=> (!mem_req || $stable(mem_addr)))
		else $error("mem_addr changed while mem_req was high");

	// one handshake at a time
	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(inst_ack && mem_req))
		else $error("inst_ack and mem_req were high together");

endmodule

`default_nettype wire

// ==== tests/exec_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb
	import core_pkg::*;
	import isa_pkg::*;
();

	localparam int NUM_TESTS       = 5;
	localparam int RESET_CYCLES    = 3;
	localparam int WATCHDOG_CYCLES = NUM_TESTS * (4 * BUS_TIMEOUT + 20);
	localparam int ACK_LIMIT       = 4 * BUS_TIMEOUT;

	logic     clk;
	logic     rst_n;
	logic     inst_req;
	inst_t    inst;
	logic     inst_ack;
	logic     mem_req;
	logic     mem_we;
	word_t    mem_addr;
	word_t    mem_wdata;
	logic     mem_ack = 1'b0;
	word_t    mem_rdata = '0;
	reg_idx_t dbg_idx;
	word_t    dbg_data;
	logic     bus_err;

	word_t       mem_arr [256];
	word_t       exp_regs [NUM_REGS];
	int          ack_delay;
	int          wait_cnt;
	logic        mem_hang;
	logic [31:0] lfsr;
	int          errors;
	int          mem_errors = 0;

	exec_core dut_i (
		.clk(clk), .rst_n(rst_n),
		.inst_req(inst_req), .inst(inst), .inst_ack(inst_ack),
		.mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_ack(mem_ack), .mem_rdata(mem_rdata),
		.dbg_idx(dbg_idx), .dbg_data(dbg_data), .bus_err(bus_err)
	);

	bind exec_core exec_core_chk chk_i (
		.clk(clk), .rst_n(rst_n), .inst_req(inst_req), .inst_ack(inst_ack),
		.mem_req(mem_req), .mem_ack(mem_ack), .mem_addr(mem_addr), .bus_err(bus_err)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic take_bits(input int n, output int val);
		val = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			val = (val << 1) | int'(lfsr[0]);
		end
	endtask

	function automatic word_t fill_word(input int a);
		return 32'h5a00_0000 ^ (word_t'(a) << 16) ^ (word_t'(a) << 2);
	endfunction

	function automatic logic [7:0] word_index(input word_t addr);
		return addr[9:2];
	endfunction

	function automatic word_t sext15(input logic [14:0] v);
		return {{17{v[14]}}, v};
	endfunction

	function automatic word_t zext15(input logic [14:0] v);
		return {17'b0, v};
	endfunction

	function automatic word_t sext20(input logic [19:0] v);
		return {{12{v[19]}}, v};
	endfunction

	function automatic inst_t enc_r(input opcode_t op, input reg_idx_t rt, input reg_idx_t ra,
			input reg_idx_t rb, input shamt_t sv);
		inst_t i;
		i.op = op;
		i.rt = rt;
		i.ra = ra;
		i.tail = {rb, sv, 8'b0};
		return i;
	endfunction

	function automatic inst_t enc_i(input opcode_t op, input reg_idx_t rt, input reg_idx_t ra,
			input logic [14:0] imm);
		inst_t i;
		i.op = op;
		i.rt = rt;
		i.ra = ra;
		i.tail = imm;
		return i;
	endfunction

	// imm20 spans ra and tail
	function automatic inst_t enc_u(input opcode_t op, input reg_idx_t rt,
			input logic [19:0] imm);
		inst_t i;
		i.op = op;
		i.rt = rt;
		i.ra = imm[19:15];
		i.tail = imm[14:0];
		return i;
	endfunction

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("Fail %s expected %b actual %b", name, exp, act);
		end
	endtask

	task automatic read_reg(input reg_idx_t idx, output word_t val);
		@(posedge clk);
		dbg_idx <= idx;
		@(negedge clk);
		val = dbg_data;
	endtask

	task automatic expect_reg(input string name, input reg_idx_t idx);
		word_t val;
		read_reg(idx, val);
		check_word(name, exp_regs[idx], val);
	endtask

	// four-phase issue; lat counts edges after the request is sampled
	task automatic issue(input inst_t i, output int lat);
		lat = 0;
		@(posedge clk);
		inst_req <= 1'b1;
		inst <= i;
		@(posedge clk);
		@(negedge clk);
		while (!inst_ack && (lat < ACK_LIMIT)) begin
			@(negedge clk);
			lat++;
		end
		if (!inst_ack) begin
			errors++;
			$display("inst_ack never came for opcode %s", i.op.name());
		end
		@(posedge clk);
		inst_req <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_flag("inst_ack release", 1'b0, inst_ack);
	endtask

	task automatic run_reg_op(input string name, input inst_t i, input word_t exp);
		int lat;
		issue(i, lat);
		check_word({name, " latency"}, word_t'(3), word_t'(lat));
		exp_regs[i.rt] = exp;
		expect_reg(name, i.rt);
	endtask

	task automatic run_mem_op(input inst_t i);
		int lat;
		int d;
		take_bits(4, d);
		ack_delay = d % (BUS_TIMEOUT - 1);
		issue(i, lat);
	endtask

	// memory model, four-phase, ack after ack_delay waiting edges
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int a = 0; a < 256; a++) begin
				mem_arr[a] <= fill_word(a);
			end
			mem_ack <= 1'b0;
			mem_rdata <= '0;
			wait_cnt <= 0;
		end else if (!mem_req) begin
			wait_cnt <= 0;
			mem_ack <= 1'b0;
		end else if (!mem_ack && !mem_hang) begin
			if (wait_cnt < ack_delay) begin
				wait_cnt <= wait_cnt + 1;
			end else begin
				mem_ack <= 1'b1;
				if (mem_addr[31:10] != '0) begin
					mem_errors++;
					$display("memory access outside the model at address %h", mem_addr);
				end
				if (mem_we) begin
					mem_arr[word_index(mem_addr)] <= mem_wdata;
				end else begin
					mem_rdata <= mem_arr[word_index(mem_addr)];
				end
			end
		end
	end

	task automatic reset_state_test();
		word_t val;
		@(negedge clk);
		check_flag("reset inst_ack", 1'b0, inst_ack);
		check_flag("reset mem_req", 1'b0, mem_req);
		check_flag("reset mem_we", 1'b0, mem_we);
		check_flag("reset bus_err", 1'b0, bus_err);
		for (int r = 0; r < NUM_REGS; r++) begin
			read_reg(reg_idx_t'(r), val);
			check_word($sformatf("reset r%0d", r), '0, val);
		end
	endtask

	task automatic reg_alu_test();
		run_reg_op("reg_alu movi", enc_u(OP_MOVI, 5'd1, 20'h12345), sext20(20'h12345));
		run_reg_op("reg_alu sethi", enc_u(OP_SETHI, 5'd2, 20'habcde),
			word_t'(20'habcde) << 12);
		run_reg_op("reg_alu ori", enc_i(OP_ORI, 5'd2, 5'd2, 15'h1234),
			exp_regs[2] | zext15(15'h1234));
		run_reg_op("reg_alu movi r6", enc_u(OP_MOVI, 5'd6, 20'h12345), sext20(20'h12345));
		run_reg_op("reg_alu add", enc_r(OP_ADD, 5'd7, 5'd1, 5'd2, 2'd0),
			exp_regs[1] + exp_regs[2]);
		run_reg_op("reg_alu sub", enc_r(OP_SUB, 5'd8, 5'd2, 5'd1, 2'd0),
			exp_regs[2] - exp_regs[1]);
		run_reg_op("reg_alu and", enc_r(OP_AND, 5'd9, 5'd1, 5'd2, 2'd0),
			exp_regs[1] & exp_regs[2]);
		run_reg_op("reg_alu or", enc_r(OP_OR, 5'd10, 5'd1, 5'd2, 2'd0),
			exp_regs[1] | exp_regs[2]);
		run_reg_op("reg_alu xor", enc_r(OP_XOR, 5'd11, 5'd1, 5'd2, 2'd0),
			exp_regs[1] ^ exp_regs[2]);
		// seq compares ra with rt and overwrites rt
		run_reg_op("reg_alu seq equal", enc_r(OP_SEQ, 5'd6, 5'd1, 5'd0, 2'd0),
			word_t'(exp_regs[1] == exp_regs[6]));
		run_reg_op("reg_alu seq differ", enc_r(OP_SEQ, 5'd6, 5'd1, 5'd0, 2'd0),
			word_t'(exp_regs[1] == exp_regs[6]));
		run_reg_op("reg_alu slli", enc_i(OP_SLLI, 5'd12, 5'd2, 15'd7), exp_regs[2] << 7);
	endtask

	task automatic imm_forms_test();
		run_reg_op("imm addi negative", enc_i(OP_ADDI, 5'd13, 5'd1, 15'h7ff0),
			exp_regs[1] + sext15(15'h7ff0));
		run_reg_op("imm ori top bit", enc_i(OP_ORI, 5'd14, 5'd1, 15'h4001),
			exp_regs[1] | zext15(15'h4001));
		run_reg_op("imm movi negative", enc_u(OP_MOVI, 5'd15, 20'hfff00), sext20(20'hfff00));
		run_reg_op("imm sethi", enc_u(OP_SETHI, 5'd16, 20'h80001), word_t'(20'h80001) << 12);
	endtask

	task automatic load_store_test();
		word_t addr;
		run_reg_op("ls base", enc_u(OP_MOVI, 5'd3, 20'h00100), sext20(20'h00100));
		run_reg_op("ls index", enc_u(OP_MOVI, 5'd5, 20'h00004), sext20(20'h00004));
		addr = exp_regs[3] + (sext15(15'd5) << 2);
		run_mem_op(enc_i(OP_SWI, 5'd2, 5'd3, 15'd5));
		check_word("ls swi memory", exp_regs[2], mem_arr[word_index(addr)]);
		run_mem_op(enc_i(OP_LWI, 5'd4, 5'd3, 15'd5));
		exp_regs[4] = exp_regs[2];
		expect_reg("ls lwi", 5'd4);
		for (int sv = 0; sv < 4; sv++) begin
			addr = exp_regs[3] + (exp_regs[5] << sv);
			run_mem_op(enc_r(OP_LW, reg_idx_t'(17 + sv), 5'd3, 5'd5, shamt_t'(sv)));
			exp_regs[reg_idx_t'(17 + sv)] = fill_word(int'(word_index(addr)));
			expect_reg($sformatf("ls lw sv%0d", sv), reg_idx_t'(17 + sv));
		end
		check_flag("ls bus_err", 1'b0, bus_err);
	endtask

	task automatic timeout_test();
		int lat;
		check_flag("timeout bus_err before", 1'b0, bus_err);
		mem_hang = 1'b1;
		issue(enc_i(OP_LWI, 5'd4, 5'd3, 15'd0), lat);
		mem_hang = 1'b0;
		check_flag("timeout bus_err", 1'b1, bus_err);
		check_flag("timeout mem_req", 1'b0, mem_req);
		expect_reg("timeout rt kept", 5'd4);
		run_reg_op("timeout add", enc_r(OP_ADD, 5'd18, 5'd1, 5'd2, 2'd0),
			exp_regs[1] + exp_regs[2]);
		check_flag("timeout bus_err sticky", 1'b1, bus_err);
	endtask

	initial begin
		inst_req = 1'b0;
		inst = '0;
		dbg_idx = '0;
		rst_n = 1'b0;
		mem_hang = 1'b0;
		ack_delay = 0;
		lfsr = 32'h3c7d;
		errors = 0;
		for (int r = 0; r < NUM_REGS; r++) begin
			exp_regs[r] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		reset_state_test();
		reg_alu_test();
		imm_forms_test();
		load_store_test();
		timeout_test();
		$display("errors: %0d in checks, %0d in memory model", errors, mem_errors);
		if ((errors == 0) && (mem_errors == 0)) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (WATCHDOG_CYCLES + RESET_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, the tests did not finish",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
logic/core_pkg.sv
logic/isa_pkg.sv
logic/muxs.sv
logic/alu.sv
logic/reg_file.sv
logic/bus_timer.sv
logic/core_fsm.sv
logic/exec_core.sv
tests/exec_core_chk.sv
tests/exec_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the exec_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f tb.f --top-module exec_core_tb -o exec_core_sim; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/exec_core_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
	echo "PASS"
	exit 0
fi

echo "FAIL: pass message not found in sim.log"
exit 1
